// ==== src.f ====
design/switch_pkg.sv
design/rr_arbiter.sv
design/ingress_port.sv
design/cell_buffer.sv
design/queue_manager.sv
design/prio_dispatch.sv
design/egress_port.sv
design/switch_top.sv
testbench/switch_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module switch_tb -f src.f -o switch_sim
./obj_dir/switch_sim > sim.log 2>&1
cat sim.log

if grep -q "SIMULATION FAILED" sim.log; then
    exit 1
fi
if ! grep -q "SIMULATION PASSED" sim.log; then
    echo "no result line in sim.log"
    exit 1
fi
exit 0

// ==== testbench/switch_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module switch_tb import switch_pkg::*; ();

    logic                             clk;
    logic                             rst_n;
    logic [NUM_PORTS-1:0]             wr_sop, wr_eop, wr_vld, pause, ready;
    logic [NUM_PORTS-1:0]             rd_sop, rd_eop, rd_vld, wrr_enable;
    logic [NUM_PORTS-1:0][DATA_W-1:0] wr_data, rd_data;

    logic [31:0] seed = 32'hebce1db0;
    int errors, checks, tests, failed_tests, err_mark;
    int acc_count, enq_count;
    int cycles_since_reset;
    // 0 low, 1 high, 2 random per cycle
    int ready_mode;
    logic [NUM_PORTS-1:0] wrr_mode;

    // sender words as {sop, eop, data}
    logic [DATA_W+1:0]    src_q [NUM_PORTS][$];
    logic [NUM_PORTS-1:0] took;
    // reference model state
    logic [DATA_W-1:0]    in_words [NUM_PORTS][$];
    int                   in_dest [NUM_PORTS];
    int                   in_prio [NUM_PORTS];
    logic [DATA_W-1:0]    pq_word [NUM_PORTS][NUM_PRIO][$];
    int                   pq_len [NUM_PORTS][NUM_PRIO][$];
    logic [DATA_W-1:0]    fly [NUM_PORTS][$];
    logic [NUM_PORTS-1:0] busy_m, first_m, ready_prev;
    int                   wrr_cur [NUM_PORTS];
    int                   wrr_cnt [NUM_PORTS];

    switch_top UUT (
        .clk(clk), .rst_n(rst_n),
        .wr_sop(wr_sop), .wr_eop(wr_eop), .wr_vld(wr_vld), .wr_data(wr_data),
        .pause(pause), .ready(ready),
        .rd_sop(rd_sop), .rd_eop(rd_eop), .rd_vld(rd_vld), .rd_data(rd_data),
        .wrr_enable(wrr_enable)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] rand_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    task automatic check_val(string name, logic [31:0] got, logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic report_timeout(string what);
        errors++;
        $display("timeout while waiting for %s", what);
    endtask

    task automatic model_clear();
        for (int p = 0; p < NUM_PORTS; p++) begin
            src_q[p].delete();
            in_words[p].delete();
            fly[p].delete();
            wrr_cur[p] = 0;
            wrr_cnt[p] = 0;
            for (int q = 0; q < NUM_PRIO; q++) begin
                pq_word[p][q].delete();
                pq_len[p][q].delete();
            end
        end
        took       = '0;
        busy_m     = '0;
        first_m    = '0;
        ready_prev = '0;
        acc_count  = 0;
        enq_count  = 0;
        cycles_since_reset = 0;
    endtask

    task automatic queue_packet(int src, int dest, int prio, int len);
        hdr_word_t h;
        h.fld.dest = PORT_W'(dest);
        h.fld.prio = PRIO_W'(prio);
        h.fld.tag  = 12'(rand_next());
        src_q[src].push_back({1'b1, 1'b0, h.raw});
        for (int i = 1; i < len; i++) begin
            src_q[src].push_back({1'b0, i == len - 1, 16'(rand_next())});
        end
    endtask

    // next packet for an idle output, strict or weighted round robin
    task automatic pick_packet(int o);
        int pr;
        int n;
        pr = -1;
        if (busy_m[o]) return;
        if (!wrr_mode[o]) begin
            for (int q = NUM_PRIO - 1; q >= 0; q--) begin
                if (pq_len[o][q].size() != 0) pr = q;
            end
        end else if (pq_len[o][wrr_cur[o]].size() != 0
                     && wrr_cnt[o] < int'(WRR_WEIGHT[wrr_cur[o]])) begin
            pr = wrr_cur[o];
            wrr_cnt[o]++;
        end else begin
            for (int i = NUM_PRIO; i >= 1; i--) begin
                if (pq_len[o][(wrr_cur[o] + i) % NUM_PRIO].size() != 0) begin
                    pr = (wrr_cur[o] + i) % NUM_PRIO;
                end
            end
            if (pr >= 0) begin
                wrr_cur[o] = pr;
                wrr_cnt[o] = 1;
            end
        end
        if (pr < 0) return;
        n = pq_len[o][pr].pop_front();
        repeat (n) fly[o].push_back(pq_word[o][pr].pop_front());
        busy_m[o]  = 1'b1;
        first_m[o] = 1'b1;
    endtask

    task automatic sample_cycle();
        hdr_word_t h;
        logic [DATA_W-1:0] exp;
        // free list still filling, no input may be taken
        if (cycles_since_reset < CELL_COUNT) begin
            check_val("pause", 32'(pause), 32'({NUM_PORTS{1'b1}}));
        end
        cycles_since_reset++;
        for (int o = 0; o < NUM_PORTS; o++) begin
            if (rd_vld[o]) begin
                if (!ready_prev[o]) begin
                    errors++;
                    $display("output %0d delivered a word that was not requested", o);
                end
                if (!busy_m[o]) begin
                    errors++;
                    $display("output %0d delivered a word with no packet expected", o);
                end else begin
                    exp = fly[o].pop_front();
                    check_val($sformatf("rd_data[%0d]", o), 32'(rd_data[o]), 32'(exp));
                    check_val($sformatf("rd_sop[%0d]", o), 32'(rd_sop[o]), 32'(first_m[o]));
                    check_val($sformatf("rd_eop[%0d]", o), 32'(rd_eop[o]),
                              32'(fly[o].size() == 0));
                    first_m[o] = 1'b0;
                    if (fly[o].size() == 0) busy_m[o] = 1'b0;
                end
            end
            ready_prev[o] = ready[o];
        end
        for (int p = 0; p < NUM_PORTS; p++) begin
            took[p] = wr_vld[p] && !pause[p];
            if (took[p]) begin
                acc_count++;
                if (wr_sop[p]) begin
                    h.raw      = wr_data[p];
                    in_dest[p] = int'(h.fld.dest);
                    in_prio[p] = int'(h.fld.prio);
                end
                in_words[p].push_back(wr_data[p]);
                if (wr_eop[p]) begin
                    pq_len[in_dest[p]][in_prio[p]].push_back(in_words[p].size());
                    while (in_words[p].size() != 0) begin
                        pq_word[in_dest[p]][in_prio[p]].push_back(in_words[p].pop_front());
                    end
                    enq_count++;
                end
            end
        end
        for (int o = 0; o < NUM_PORTS; o++) pick_packet(o);
    endtask

    task automatic drive_cycle();
        logic [31:0] r;
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (took[p]) begin
                src_q[p].delete(0);
                took[p] = 1'b0;
            end
            // a paused word stays on the bus unchanged
            if (src_q[p].size() != 0) begin
                {wr_sop[p], wr_eop[p], wr_data[p]} = src_q[p][0];
                wr_vld[p] = 1'b1;
            end else begin
                wr_vld[p] = 1'b0;
                wr_sop[p] = 1'b0;
                wr_eop[p] = 1'b0;
            end
            r = rand_next();
            ready[p] = (ready_mode == 2) ? r[7] : (ready_mode == 1);
        end
        wrr_enable = wrr_mode;
    endtask

    initial begin : engine
        forever begin
            @(negedge clk);
            if (rst_n) sample_cycle();
            @(posedge clk);
            #1;
            drive_cycle();
        end
    end

    function automatic bit all_idle();
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (src_q[p].size() != 0 || in_words[p].size() != 0 || busy_m[p]) return 1'b0;
            for (int q = 0; q < NUM_PRIO; q++) begin
                if (pq_len[p][q].size() != 0) return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    task automatic wait_idle(string what, int limit);
        int n;
        n = 0;
        while (!all_idle()) begin
            if (n == limit) begin
                report_timeout(what);
                return;
            end
            @(posedge clk);
            n++;
        end
    endtask

    // counts accepted words when use_words is set, else enqueued packets
    task automatic wait_count(string what, bit use_words, int target, int limit);
        int n;
        n = 0;
        while ((use_words ? acc_count : enq_count) < target) begin
            if (n == limit) begin
                report_timeout(what);
                return;
            end
            @(posedge clk);
            n++;
        end
    endtask

    task automatic apply_reset();
        #1 rst_n = 1'b0;
        ready_mode = 0;
        repeat (10) @(posedge clk);
        model_clear();
        #1 rst_n = 1'b1;
    endtask

    task automatic end_test(string name);
        tests++;
        if (errors > err_mark) begin
            failed_tests++;
            $display("%s: failed with %0d errors", name, errors - err_mark);
        end else begin
            $display("%s: ok", name);
        end
        err_mark = errors;
    endtask

    task automatic preload_and_drain(string name, int count);
        ready_mode = 0;
        for (int k = 0; k < count; k++) begin
            queue_packet(0, 1, int'(rand_next() % 4), 2 + int'(rand_next() % 3));
        end
        wait_count({name, " preload"}, 1'b0, count, 4000);
        ready_mode = 1;
        wait_idle({name, " drain"}, 4000);
    endtask

    task automatic fill_buffer();
        ready_mode = 0;
        acc_count  = 0;
        for (int k = 0; k < 12; k++) queue_packet(k % 4, int'(rand_next() % 4), 0, 8);
        wait_count("buffer fill", 1'b1, CELL_COUNT, 4000);
        repeat (30) @(posedge clk);
        check_val("accepted words", 32'(acc_count), 32'(CELL_COUNT));
        ready_mode = 1;
        wait_idle("buffer drain", 8000);
    endtask

    initial begin : main
        rst_n      = 1'b0;
        wr_sop     = '0;
        wr_eop     = '0;
        wr_vld     = '0;
        wr_data    = '0;
        ready      = '0;
        wrr_enable = '0;
        wrr_mode   = '0;
        errors = 0;
        checks = 0;
        tests = 0;
        failed_tests = 0;
        err_mark = 0;
        apply_reset();

        ready_mode = 1;
        for (int p = 0; p < NUM_PORTS; p++) begin
            for (int k = 0; k < 6; k++) begin
                queue_packet(p, int'(rand_next() % 4), 0, 2 + int'(rand_next() % 7));
            end
        end
        wait_idle("data integrity traffic", 20000);
        end_test("data integrity");

        apply_reset();
        wrr_mode = '0;
        preload_and_drain("strict priority", 10);
        end_test("strict priority");

        apply_reset();
        wrr_mode = '1;
        preload_and_drain("weighted round robin", 14);
        end_test("weighted round robin");

        apply_reset();
        wrr_mode   = '0;
        ready_mode = 2;
        for (int p = 0; p < NUM_PORTS; p++) begin
            for (int k = 0; k < 8; k++) begin
                queue_packet(p, int'(rand_next() % 4), 0, 2 + int'(rand_next() % 7));
            end
        end
        wait_idle("back-pressure traffic", 40000);
        end_test("back-pressure");

        apply_reset();
        fill_buffer();
        fill_buffer();
        end_test("cell reuse");

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests, failed_tests, checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== design/switch_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module switch_top import switch_pkg::*; (
    input  wire                              clk,
    input  wire                              rst_n,
    input  wire  [NUM_PORTS-1:0]             wr_sop,
    input  wire  [NUM_PORTS-1:0]             wr_eop,
    input  wire  [NUM_PORTS-1:0]             wr_vld,
    input  wire  [NUM_PORTS-1:0][DATA_W-1:0] wr_data,
    output logic [NUM_PORTS-1:0]             pause,
    input  wire  [NUM_PORTS-1:0]             ready,
    output logic [NUM_PORTS-1:0]             rd_sop,
    output logic [NUM_PORTS-1:0]             rd_eop,
    output logic [NUM_PORTS-1:0]             rd_vld,
    output logic [NUM_PORTS-1:0][DATA_W-1:0] rd_data,
    input  wire  [NUM_PORTS-1:0]             wrr_enable
);

    // write side, one entry per ingress port
    logic [NUM_PORTS-1:0]                  wr_req, wr_grant, cell_we, cell_weop;
    logic [NUM_PORTS-1:0]                  link_we, enq_valid;
    logic [NUM_PORTS-1:0][DATA_W-1:0]      cell_wdata;
    logic [NUM_PORTS-1:0][CELL_ADDR_W-1:0] link_addr, enq_head, enq_tail;
    logic [NUM_PORTS-1:0][PORT_W-1:0]      enq_dest;
    logic [NUM_PORTS-1:0][PRIO_W-1:0]      enq_prio;

    // the granted writer
    logic                   m_we, m_weop, m_link_we, m_enq_valid;
    logic [DATA_W-1:0]      m_wdata;
    logic [CELL_ADDR_W-1:0] m_link_addr, m_enq_head, m_enq_tail;
    logic [PORT_W-1:0]      m_enq_dest;
    logic [PRIO_W-1:0]      m_enq_prio;

    logic [CELL_ADDR_W-1:0] free_cell, cc_addr, cc_next;
    logic                   free_avail, cc_we;

    // read side
    logic [NUM_PORTS-1:0]                  rd_req, rd_grant, eg_push, start, pop;
    logic [NUM_PORTS-1:0][CELL_ADDR_W-1:0] eg_raddr, pop_next;
    logic [NUM_PORTS-1:0][PRIO_W-1:0]      pop_prio, disp_prio;
    logic [NUM_PORTS-1:0][NUM_PRIO-1:0][CELL_ADDR_W-1:0] head_cell;
    logic [NUM_PORTS-1:0][NUM_PRIO-1:0]    present_mask;
    logic                                  m_re, reop;
    logic [CELL_ADDR_W-1:0]                m_raddr, rnext;
    logic [DATA_W-1:0]                     rdata;

    // grants are one-hot, so each buffer port takes one requester
    always_comb begin
        m_we        = 1'b0;
        m_weop      = 1'b0;
        m_wdata     = '0;
        m_link_we   = 1'b0;
        m_link_addr = '0;
        m_enq_valid = 1'b0;
        m_enq_dest  = '0;
        m_enq_prio  = '0;
        m_enq_head  = '0;
        m_enq_tail  = '0;
        m_re        = 1'b0;
        m_raddr     = '0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (wr_grant[p]) begin
                m_we        = cell_we[p];
                m_weop      = cell_weop[p];
                m_wdata     = cell_wdata[p];
                m_link_we   = link_we[p];
                m_link_addr = link_addr[p];
                m_enq_valid = enq_valid[p];
                m_enq_dest  = enq_dest[p];
                m_enq_prio  = enq_prio[p];
                m_enq_head  = enq_head[p];
                m_enq_tail  = enq_tail[p];
            end
            if (rd_grant[p]) begin
                m_re    = eg_push[p];
                m_raddr = eg_raddr[p];
            end
        end
    end

    rr_arbiter u_wr_arb (.clk(clk), .rst_n(rst_n), .req(wr_req), .grant(wr_grant));
    rr_arbiter u_rd_arb (.clk(clk), .rst_n(rst_n), .req(rd_req), .grant(rd_grant));

    cell_buffer u_buf (
        .clk(clk), .rst_n(rst_n),
        .we(m_we), .waddr(free_cell), .wdata(m_wdata), .weop(m_weop),
        .link_we_a(m_link_we), .link_addr_a(m_link_addr), .link_next_a(free_cell),
        .link_we_b(cc_we), .link_addr_b(cc_addr), .link_next_b(cc_next),
        .pop(m_we), .free_cell(free_cell), .free_avail(free_avail),
        .re(m_re), .raddr(m_raddr), .rdata(rdata), .reop(reop), .rnext(rnext),
        .push(m_re), .push_addr(m_raddr)
    );

    queue_manager u_qm (
        .clk(clk), .rst_n(rst_n),
        .enq_valid(m_enq_valid), .enq_dest(m_enq_dest), .enq_prio(m_enq_prio),
        .enq_head(m_enq_head), .enq_tail(m_enq_tail),
        .link_we(cc_we), .link_addr(cc_addr), .link_next(cc_next),
        .pop(pop), .pop_prio(pop_prio), .pop_next(pop_next),
        .head_cell(head_cell), .present_mask(present_mask)
    );

    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
        assign pause[p] = !wr_grant[p] || !free_avail;

        ingress_port u_ingress (
            .clk(clk), .rst_n(rst_n),
            .wr_sop(wr_sop[p]), .wr_eop(wr_eop[p]), .wr_vld(wr_vld[p]), .wr_data(wr_data[p]),
            .grant(wr_grant[p]), .req(wr_req[p]),
            .free_cell(free_cell), .free_avail(free_avail),
            .cell_we(cell_we[p]), .cell_wdata(cell_wdata[p]), .cell_weop(cell_weop[p]),
            .link_we(link_we[p]), .link_addr(link_addr[p]),
            .enq_valid(enq_valid[p]), .enq_dest(enq_dest[p]), .enq_prio(enq_prio[p]),
            .enq_head(enq_head[p]), .enq_tail(enq_tail[p])
        );

        prio_dispatch u_dispatch (
            .clk(clk), .rst_n(rst_n), .wrr_en(wrr_enable[p]),
            .present(present_mask[p]), .start(start[p]), .prio(disp_prio[p])
        );

        egress_port u_egress (
            .clk(clk), .rst_n(rst_n), .ready(ready[p]), .present_any(|present_mask[p]),
            .start(start[p]), .prio(disp_prio[p]), .head_cell(head_cell[p]),
            .req(rd_req[p]), .grant(rd_grant[p]), .raddr(eg_raddr[p]),
            .rdata(rdata), .reop(reop), .rnext(rnext), .free_push(eg_push[p]),
            .pop(pop[p]), .pop_prio(pop_prio[p]), .pop_next(pop_next[p]),
            .rd_sop(rd_sop[p]), .rd_eop(rd_eop[p]), .rd_vld(rd_vld[p]), .rd_data(rd_data[p])
        );
    end

endmodule

`default_nettype wire

// ==== design/egress_port.sv ====
`timescale 1ns/10ps
`default_nettype none

module egress_port import switch_pkg::*; (
    input  wire                                  clk,
    input  wire                                  rst_n,
    input  wire                                  ready,
    input  wire                                  present_any,
    output logic                                 start,
    input  wire  [PRIO_W-1:0]                    prio,
    input  wire  [NUM_PRIO-1:0][CELL_ADDR_W-1:0] head_cell,
    output logic                                 req,
    input  wire                                  grant,
    output logic [CELL_ADDR_W-1:0]               raddr,
    input  wire  [DATA_W-1:0]                    rdata,
    input  wire                                  reop,
    input  wire  [CELL_ADDR_W-1:0]               rnext,
    output logic                                 free_push,
    output logic                                 pop,
    output logic [PRIO_W-1:0]                    pop_prio,
    output logic [CELL_ADDR_W-1:0]               pop_next,
    output logic                                 rd_sop,
    output logic                                 rd_eop,
    output logic                                 rd_vld,
    output logic [DATA_W-1:0]                    rd_data
);

    logic                   busy;
    logic                   pend;
    logic                   first;
    logic                   last_seen;
    logic [CELL_ADDR_W-1:0] cur_cell;
    logic [PRIO_W-1:0]      cur_prio;

    assign start     = !busy && present_any;
    // pend means the buffer returns our word in this cycle
    assign last_seen = pend && reop;

    // follow the chain straight from the returned next pointer
    assign raddr     = pend ? rnext : cur_cell;
    assign req       = busy && ready && !last_seen;
    assign free_push = req && grant;

    assign pop      = last_seen;
    assign pop_prio = cur_prio;
    assign pop_next = rnext;

    assign rd_vld  = pend;
    assign rd_sop  = pend && first;
    assign rd_eop  = last_seen;
    assign rd_data = pend ? rdata : '0;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy  <= 1'b0;
            pend  <= 1'b0;
            first <= 1'b0;
        end else begin
            pend <= free_push;
            if (start) begin
                busy  <= 1'b1;
                first <= 1'b1;
            end else begin
                if (last_seen) begin
                    busy <= 1'b0;
                end
                if (pend) begin
                    first <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            cur_prio <= prio;
            cur_cell <= head_cell[prio];
        end else if (pend) begin
            cur_cell <= rnext;
        end
    end

endmodule

`default_nettype wire

// ==== design/prio_dispatch.sv ====
`timescale 1ns/10ps
`default_nettype none

module prio_dispatch import switch_pkg::*; (
    input  wire                clk,
    input  wire                rst_n,
    input  wire                wrr_en,
    input  wire [NUM_PRIO-1:0] present,
    input  wire                start,
    output logic [PRIO_W-1:0]  prio
);

    logic [PRIO_W-1:0] cur;
    logic [PRIO_W-1:0] strict_pick;
    logic [PRIO_W-1:0] next_pick;
    logic [WRR_W-1:0]  served;
    logic              stay;

    always_comb begin
        strict_pick = '0;
        for (int i = NUM_PRIO - 1; i >= 0; i--) begin
            if (present[i]) begin
                strict_pick = PRIO_W'(i);
            end
        end
        // next present priority after the current one, wrapping
        next_pick = cur;
        for (int i = NUM_PRIO; i >= 1; i--) begin
            if (present[cur + PRIO_W'(i)]) begin
                next_pick = cur + PRIO_W'(i);
            end
        end
        stay = present[cur] && served < WRR_WEIGHT[cur];
        if (!wrr_en) begin
            prio = strict_pick;
        end else begin
            prio = stay ? cur : next_pick;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cur    <= '0;
            served <= '0;
        end else if (start) begin
            cur    <= prio;
            served <= (wrr_en && stay) ? served + 1'b1 : WRR_W'(1);
        end
    end

endmodule

`default_nettype wire

// ==== design/queue_manager.sv ====
`timescale 1ns/10ps
`default_nettype none

module queue_manager import switch_pkg::*; (
    input  wire                                           clk,
    input  wire                                           rst_n,
    input  wire                                           enq_valid,
    input  wire  [PORT_W-1:0]                             enq_dest,
    input  wire  [PRIO_W-1:0]                             enq_prio,
    input  wire  [CELL_ADDR_W-1:0]                        enq_head,
    input  wire  [CELL_ADDR_W-1:0]                        enq_tail,
    output logic                                          link_we,
    output logic [CELL_ADDR_W-1:0]                        link_addr,
    output logic [CELL_ADDR_W-1:0]                        link_next,
    input  wire  [NUM_PORTS-1:0]                          pop,
    input  wire  [NUM_PORTS-1:0][PRIO_W-1:0]              pop_prio,
    input  wire  [NUM_PORTS-1:0][CELL_ADDR_W-1:0]         pop_next,
    output logic [NUM_PORTS-1:0][NUM_PRIO-1:0][CELL_ADDR_W-1:0] head_cell,
    output logic [NUM_PORTS-1:0][NUM_PRIO-1:0]            present_mask
);

    logic [CELL_ADDR_W-1:0] head_q [NUM_PORTS][NUM_PRIO];
    logic [CELL_ADDR_W-1:0] tail_q [NUM_PORTS][NUM_PRIO];
    logic [CELL_ADDR_W:0]   cnt_q  [NUM_PORTS][NUM_PRIO];

    logic [NUM_PORTS-1:0][NUM_PRIO-1:0] enq_hit;
    logic [NUM_PORTS-1:0][NUM_PRIO-1:0] pop_hit;
    logic [NUM_PORTS-1:0][NUM_PRIO-1:0] late_hit;
    logic [CELL_ADDR_W:0]               tgt_cnt;
    logic                               tgt_pop;

    // enqueue onto a single-packet queue one cycle ago
    logic                   late_vld;
    logic [PORT_W-1:0]      late_dest;
    logic [PRIO_W-1:0]      late_prio;
    logic [CELL_ADDR_W-1:0] late_head;

    always_comb begin
        tgt_cnt   = cnt_q[enq_dest][enq_prio];
        tgt_pop   = pop[enq_dest] && pop_prio[enq_dest] == enq_prio;
        // no join when the old tail leaves in this very cycle
        link_we   = enq_valid && tgt_cnt != '0 && !(tgt_pop && tgt_cnt == 1);
        link_addr = tail_q[enq_dest][enq_prio];
        link_next = enq_head;
        for (int p = 0; p < NUM_PORTS; p++) begin
            for (int q = 0; q < NUM_PRIO; q++) begin
                enq_hit[p][q]  = enq_valid && enq_dest == PORT_W'(p) && enq_prio == PRIO_W'(q);
                pop_hit[p][q]  = pop[p] && pop_prio[p] == PRIO_W'(q);
                late_hit[p][q] = late_vld && late_dest == PORT_W'(p) && late_prio == PRIO_W'(q);
                head_cell[p][q]    = head_q[p][q];
                present_mask[p][q] = cnt_q[p][q] != '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            late_vld <= 1'b0;
            for (int p = 0; p < NUM_PORTS; p++) begin
                for (int q = 0; q < NUM_PRIO; q++) begin
                    cnt_q[p][q] <= '0;
                end
            end
        end else begin
            late_vld <= enq_valid && tgt_cnt == 1 && !tgt_pop;
            for (int p = 0; p < NUM_PORTS; p++) begin
                for (int q = 0; q < NUM_PRIO; q++) begin
                    cnt_q[p][q] <= cnt_q[p][q] + (CELL_ADDR_W+1)'(enq_hit[p][q])
                                   - (CELL_ADDR_W+1)'(pop_hit[p][q]);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        late_dest <= enq_dest;
        late_prio <= enq_prio;
        late_head <= enq_head;
        for (int p = 0; p < NUM_PORTS; p++) begin
            for (int q = 0; q < NUM_PRIO; q++) begin
                if (enq_hit[p][q]) begin
                    tail_q[p][q] <= enq_tail;
                end
                if (pop_hit[p][q]) begin
                    // eop cell's next pointer may be older than the join
                    if (enq_hit[p][q] && cnt_q[p][q] == 1) begin
                        head_q[p][q] <= enq_head;
                    end else if (late_hit[p][q]) begin
                        head_q[p][q] <= late_head;
                    end else begin
                        head_q[p][q] <= pop_next[p];
                    end
                end else if (enq_hit[p][q] && cnt_q[p][q] == '0) begin
                    head_q[p][q] <= enq_head;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/cell_buffer.sv ====
`timescale 1ns/10ps
`default_nettype none

module cell_buffer import switch_pkg::*; (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire                    we,
    input  wire [CELL_ADDR_W-1:0]  waddr,
    input  wire [DATA_W-1:0]       wdata,
    input  wire                    weop,
    input  wire                    link_we_a,
    input  wire [CELL_ADDR_W-1:0]  link_addr_a,
    input  wire [CELL_ADDR_W-1:0]  link_next_a,
    input  wire                    link_we_b,
    input  wire [CELL_ADDR_W-1:0]  link_addr_b,
    input  wire [CELL_ADDR_W-1:0]  link_next_b,
    input  wire                    pop,
    output logic [CELL_ADDR_W-1:0] free_cell,
    output logic                   free_avail,
    input  wire                    re,
    input  wire [CELL_ADDR_W-1:0]  raddr,
    output logic [DATA_W-1:0]      rdata,
    output logic                   reop,
    output logic [CELL_ADDR_W-1:0] rnext,
    input  wire                    push,
    input  wire [CELL_ADDR_W-1:0]  push_addr
);

    logic [DATA_W-1:0]      data_mem [CELL_COUNT];
    logic                   eop_mem  [CELL_COUNT];
    logic [CELL_ADDR_W-1:0] next_mem [CELL_COUNT];
    logic [CELL_ADDR_W-1:0] free_mem [CELL_COUNT];

    logic [CELL_ADDR_W-1:0] rd_ptr;
    logic [CELL_ADDR_W-1:0] wr_ptr;
    logic [CELL_ADDR_W:0]   free_cnt;
    logic [CELL_ADDR_W:0]   fill_cnt;
    logic                   filling;
    logic                   pop_en;
    logic                   push_en;
    logic [CELL_ADDR_W-1:0] push_cell;

    // every cell is pushed once after reset
    assign filling    = fill_cnt != (CELL_ADDR_W+1)'(CELL_COUNT);
    assign free_avail = !filling && free_cnt != '0;
    assign free_cell  = free_mem[rd_ptr];
    assign pop_en     = pop && free_avail;
    assign push_en    = filling || push;
    assign push_cell  = filling ? fill_cnt[CELL_ADDR_W-1:0] : push_addr;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fill_cnt <= '0;
            free_cnt <= '0;
            rd_ptr   <= '0;
            wr_ptr   <= '0;
        end else begin
            if (filling) begin
                fill_cnt <= fill_cnt + 1'b1;
            end
            if (push_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            free_cnt <= free_cnt + (CELL_ADDR_W+1)'(push_en) - (CELL_ADDR_W+1)'(pop_en);
        end
    end

    always_ff @(posedge clk) begin
        if (push_en) begin
            free_mem[wr_ptr] <= push_cell;
        end
        if (we) begin
            data_mem[waddr] <= wdata;
            eop_mem[waddr]  <= weop;
        end
        // port a links cells inside a packet, port b joins packets
        if (link_we_a) begin
            next_mem[link_addr_a] <= link_next_a;
        end
        if (link_we_b) begin
            next_mem[link_addr_b] <= link_next_b;
        end
        if (re) begin
            rdata <= data_mem[raddr];
            reop  <= eop_mem[raddr];
            rnext <= next_mem[raddr];
        end
    end

endmodule

`default_nettype wire

// ==== design/ingress_port.sv ====
`timescale 1ns/10ps
`default_nettype none

module ingress_port import switch_pkg::*; (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire                    wr_sop,
    input  wire                    wr_eop,
    input  wire                    wr_vld,
    input  wire [DATA_W-1:0]       wr_data,
    input  wire                    grant,
    output logic                   req,
    input  wire [CELL_ADDR_W-1:0]  free_cell,
    input  wire                    free_avail,
    output logic                   cell_we,
    output logic [DATA_W-1:0]      cell_wdata,
    output logic                   cell_weop,
    output logic                   link_we,
    output logic [CELL_ADDR_W-1:0] link_addr,
    output logic                   enq_valid,
    output logic [PORT_W-1:0]      enq_dest,
    output logic [PRIO_W-1:0]      enq_prio,
    output logic [CELL_ADDR_W-1:0] enq_head,
    output logic [CELL_ADDR_W-1:0] enq_tail
);

    hdr_word_t              hdr;
    logic                   accept;
    logic                   in_pkt;
    logic [PORT_W-1:0]      dest_q;
    logic [PRIO_W-1:0]      prio_q;
    logic [CELL_ADDR_W-1:0] head_q;
    logic [CELL_ADDR_W-1:0] last_q;

    assign hdr.raw = wr_data;

    // only ask for the write slot when a cell can be taken
    assign req    = wr_vld && free_avail;
    assign accept = grant && free_avail;

    assign cell_we    = accept;
    assign cell_wdata = hdr.raw;
    assign cell_weop  = wr_eop;

    // chain the previous cell of this packet to the new one
    assign link_we   = accept && in_pkt;
    assign link_addr = last_q;

    assign enq_valid = accept && wr_eop;
    assign enq_dest  = in_pkt ? dest_q : hdr.fld.dest;
    assign enq_prio  = in_pkt ? prio_q : hdr.fld.prio;
    assign enq_head  = in_pkt ? head_q : free_cell;
    assign enq_tail  = free_cell;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            in_pkt <= 1'b0;
        end else if (accept) begin
            in_pkt <= !wr_eop;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            last_q <= free_cell;
        end
        if (accept && wr_sop) begin
            dest_q <= hdr.fld.dest;
            prio_q <= hdr.fld.prio;
            head_q <= free_cell;
        end
    end

endmodule

`default_nettype wire

// ==== design/rr_arbiter.sv ====
`timescale 1ns/10ps
`default_nettype none

module rr_arbiter (
    input  wire        clk,
    input  wire        rst_n,
    input  wire  [3:0] req,
    output logic [3:0] grant
);

    logic [1:0] last;
    logic [1:0] pick;
    logic       found;

    always_comb begin
        pick  = last;
        found = 1'b0;
        // search starts just after the previous winner
        for (int i = 1; i <= 4; i++) begin
            if (!found && req[last + 2'(i)]) begin
                found = 1'b1;
                pick  = last + 2'(i);
            end
        end
        grant = found ? (4'b0001 << pick) : 4'b0000;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            // requester 0 wins first after reset
            last <= 2'd3;
        end else if (found) begin
            last <= pick;
        end
    end

endmodule

`default_nettype wire

// ==== design/switch_pkg.sv ====
`default_nettype none

package switch_pkg;

    localparam int NUM_PORTS   = 4;
    // priority 0 is served first
    localparam int NUM_PRIO    = 4;
    localparam int DATA_W      = 16;
    localparam int CELL_COUNT  = 64;
    localparam int CELL_ADDR_W = 6;
    localparam int PORT_W      = 2;
    localparam int PRIO_W      = 2;
    localparam int WRR_W       = 3;

    // packets per turn, index is the priority
    localparam logic [NUM_PRIO-1:0][WRR_W-1:0] WRR_WEIGHT = {3'd1, 3'd2, 3'd3, 3'd4};

    // first word of a packet, seen either raw or as header fields
    typedef union packed {
        logic [DATA_W-1:0] raw;
        struct packed {
            logic [PORT_W-1:0] dest;
            logic [PRIO_W-1:0] prio;
            logic [11:0]       tag;
        } fld;
    } hdr_word_t;

endpackage

`default_nettype wire
